//--- cpu_pkg.sv
// cpu package: word types, instruction formats, control encodings shared by the whole cpu
package cpu_pkg;

	localparam int WORD_W = 16;
	localparam int ADDR_W = 9;
	localparam int REG_W = 3;
	localparam int NUM_REGS = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [REG_W-1:0] reg_num_t;

	localparam addr_t RESET_PC = '0;

	// op field values that split the MOVE class
	localparam logic [1:0] OP_MOVI = 2'b10;
	localparam logic [1:0] OP_MOVR = 2'b00;
	localparam logic [1:0] OP_ONLY = 2'b00; // load, store, branch and halt

	typedef enum logic [2:0] {
		BRANCH = 3'b001,
		LOAD = 3'b011,
		STORE = 3'b100,
		ALU = 3'b101,
		MOVE = 3'b110,
		HALT = 3'b111
	} opcode_t;

	typedef enum logic [1:0] {ADD = 2'b00, SUB = 2'b01, AND = 2'b10, NOT_B = 2'b11} alu_op_t;

	typedef enum logic [1:0] {SH_NONE, SH_LSL, SH_LSR, SH_ASR} shift_t;

	typedef enum logic [2:0] {ALWAYS, EQ, NE, LT, LE} cond_t;

	typedef enum logic [1:0] {MNONE = 2'b00, MREAD = 2'b01, MWRITE = 2'b10} mem_cmd_t;

	typedef enum logic [1:0] {WB_C, WB_IMM, WB_MEM} wb_src_t;

	typedef enum logic [1:0] {SEL_RN, SEL_RD, SEL_RM} reg_sel_t;

	typedef enum logic [4:0] {
		S_RESET, S_IF1, S_IF2, S_UPDATE_PC,
		S_MOVI,
		S_MOVR_1, S_MOVR_2, S_MOVR_3,
		S_ALU_1, S_ALU_2, S_ALU_3, S_ALU_4,
		S_CMP_1, S_CMP_2, S_CMP_3,
		S_LDR_1, S_LDR_2, S_LDR_3, S_LDR_4, S_LDR_5,
		S_STR_1, S_STR_2, S_STR_3, S_STR_4, S_STR_5, S_STR_6,
		S_BRANCH,
		S_HALT
	} state_t;

	typedef struct packed {
		opcode_t opcode;
		alu_op_t op;
		reg_num_t rn;
		reg_num_t rd;
		shift_t shift;
		reg_num_t rm;
	} instr_reg_t;

	typedef struct packed {
		opcode_t opcode;
		logic [1:0] op;
		logic [2:0] rn_or_cond; // Rn for MOVI, condition for branches
		logic [7:0] imm8; // low five bits double as imm5
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_t;

	typedef struct packed {
		reg_sel_t reg_sel;
		logic write;
		logic load_a;
		logic load_b;
		logic load_c;
		logic load_s;
		logic a_zero; // A forced to zero
		logic b_imm; // B replaced by sximm5
		wb_src_t wb_src;
	} ctrl_t;

	localparam ctrl_t CTRL_IDLE = '{
		reg_sel: SEL_RN,
		write: 1'b0,
		load_a: 1'b0,
		load_b: 1'b0,
		load_c: 1'b0,
		load_s: 1'b0,
		a_zero: 1'b0,
		b_imm: 1'b0,
		wb_src: WB_C
	};

	typedef struct packed {
		logic z;
		logic n;
		logic v;
	} flags_t;

endpackage

//--- cpu_control.sv
// cpu control FSM, sequences fetch and the per-instruction execute states
`timescale 1ns/10ps

module cpu_control import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input instr_t instr,
	input flags_t flags,
	output ctrl_t ctrl,
	output logic load_ir,
	output logic load_pc,
	output logic reset_pc,
	output logic take_branch,
	output logic addr_from_pc,
	output logic load_addr,
	output mem_cmd_t mem_cmd,
	output logic halt
);

	state_t state;
	state_t next_state;
	state_t decoded;
	cond_t cond;
	logic cond_met;

	assign cond = cond_t'(instr.i.rn_or_cond);

	// condition check on the flags left by the latest compare
	always_comb begin
		case (cond)
			ALWAYS: cond_met = 1'b1;
			EQ: cond_met = flags.z;
			NE: cond_met = ~flags.z;
			LT: cond_met = flags.n ^ flags.v;
			LE: cond_met = (flags.n ^ flags.v) | flags.z;
			default: cond_met = 1'b0; // unused encodings never branch
		endcase
	end

	// first execute state, picked from opcode and op
	always_comb begin
		case (instr.r.opcode)
			MOVE: begin
				if (instr.i.op == OP_MOVI)
					decoded = S_MOVI;
				else if (instr.i.op == OP_MOVR)
					decoded = S_MOVR_1;
				else
					decoded = S_RESET;
			end
			ALU: begin
				case (instr.r.op)
					ADD, AND: decoded = S_ALU_1;
					SUB: decoded = S_CMP_1; // compare only sets flags
					NOT_B: decoded = S_MOVR_1; // same sequence as a register move
					default: decoded = S_RESET;
				endcase
			end
			LOAD: decoded = (instr.i.op == OP_ONLY) ? S_LDR_1 : S_RESET;
			STORE: decoded = (instr.i.op == OP_ONLY) ? S_STR_1 : S_RESET;
			BRANCH: decoded = (instr.i.op == OP_ONLY) ? S_BRANCH : S_RESET;
			HALT: decoded = (instr.i.op == OP_ONLY) ? S_HALT : S_RESET;
			default: decoded = S_RESET;
		endcase
	end

	always_comb begin
		case (state)
			S_RESET: next_state = S_IF1;
			S_IF1: next_state = S_IF2;
			S_IF2: next_state = S_UPDATE_PC;
			S_UPDATE_PC: next_state = decoded;
			S_MOVR_1: next_state = S_MOVR_2;
			S_MOVR_2: next_state = S_MOVR_3;
			S_ALU_1: next_state = S_ALU_2;
			S_ALU_2: next_state = S_ALU_3;
			S_ALU_3: next_state = S_ALU_4;
			S_CMP_1: next_state = S_CMP_2;
			S_CMP_2: next_state = S_CMP_3;
			S_LDR_1: next_state = S_LDR_2;
			S_LDR_2: next_state = S_LDR_3;
			S_LDR_3: next_state = S_LDR_4;
			S_LDR_4: next_state = S_LDR_5;
			S_STR_1: next_state = S_STR_2;
			S_STR_2: next_state = S_STR_3;
			S_STR_3: next_state = S_STR_4;
			S_STR_4: next_state = S_STR_5;
			S_STR_5: next_state = S_STR_6;
			S_HALT: next_state = S_HALT; // held until reset
			S_MOVI, S_MOVR_3, S_ALU_4, S_CMP_3, S_LDR_5, S_STR_6, S_BRANCH:
				next_state = S_IF1;
			default: next_state = S_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= S_RESET;
		else
			state <= next_state;
	end

	// output table, everything idle unless the state says otherwise
	always_comb begin
		ctrl = CTRL_IDLE;
		load_ir = 1'b0;
		load_pc = 1'b0;
		reset_pc = 1'b0;
		take_branch = 1'b0;
		addr_from_pc = 1'b0;
		load_addr = 1'b0;
		mem_cmd = MNONE;
		halt = 1'b0;
		case (state)
			S_RESET: begin
				load_pc = 1'b1;
				reset_pc = 1'b1;
			end
			S_IF1: begin
				addr_from_pc = 1'b1;
				mem_cmd = MREAD;
			end
			S_IF2: begin
				addr_from_pc = 1'b1;
				mem_cmd = MREAD;
				load_ir = 1'b1; // read data valid one cycle after IF1
			end
			S_UPDATE_PC: load_pc = 1'b1;
			S_MOVI: begin
				ctrl.write = 1'b1;
				ctrl.wb_src = WB_IMM;
			end
			S_MOVR_1, S_ALU_2, S_CMP_2: begin
				ctrl.reg_sel = SEL_RM;
				ctrl.load_b = 1'b1;
			end
			S_MOVR_2, S_STR_4: begin
				ctrl.a_zero = 1'b1; // C gets B alone
				ctrl.load_c = 1'b1;
			end
			S_MOVR_3, S_ALU_4: begin
				ctrl.reg_sel = SEL_RD;
				ctrl.write = 1'b1;
			end
			S_ALU_1, S_CMP_1, S_LDR_1, S_STR_1: ctrl.load_a = 1'b1;
			S_ALU_3: ctrl.load_c = 1'b1;
			S_CMP_3: ctrl.load_s = 1'b1;
			S_LDR_2, S_STR_2: begin
				ctrl.b_imm = 1'b1; // Rn + sximm5 into C
				ctrl.load_c = 1'b1;
			end
			S_LDR_3: begin
				load_addr = 1'b1;
				mem_cmd = MREAD;
			end
			S_LDR_4: mem_cmd = MREAD;
			S_LDR_5: begin
				mem_cmd = MREAD;
				ctrl.reg_sel = SEL_RD;
				ctrl.write = 1'b1;
				ctrl.wb_src = WB_MEM;
			end
			S_STR_3: begin
				load_addr = 1'b1;
				ctrl.reg_sel = SEL_RD; // store data into B, unshifted
				ctrl.load_b = 1'b1;
			end
			S_STR_5, S_STR_6: mem_cmd = MWRITE;
			S_BRANCH: begin
				take_branch = cond_met;
				load_pc = cond_met; // PC already points past the branch
			end
			S_HALT: begin
				halt = 1'b1;
				load_pc = 1'b1;
				reset_pc = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- fetch_decode.sv
// fetch and decode, holds IR, PC and data address and splits out register numbers and immediates
`timescale 1ns/10ps

module fetch_decode import cpu_pkg::*; (
	input logic clk,
	input word_t read_data,
	input word_t datapath_out,
	input reg_sel_t reg_sel,
	input logic load_ir,
	input logic load_pc,
	input logic reset_pc,
	input logic take_branch,
	input logic addr_from_pc,
	input logic load_addr,
	output instr_t instr,
	output reg_num_t read_num,
	output reg_num_t write_num,
	output word_t sximm5,
	output word_t sximm8,
	output addr_t mem_addr
);

	addr_t pc;
	addr_t next_pc;
	addr_t data_addr;
	reg_num_t reg_num;

	always_ff @(posedge clk) begin
		if (load_ir)
			instr <= read_data;
	end

	// reset value wins over branch, branch over increment
	always_comb begin
		if (reset_pc)
			next_pc = RESET_PC;
		else if (take_branch)
			next_pc = pc + sximm8[ADDR_W-1:0];
		else
			next_pc = pc + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (load_pc)
			pc <= next_pc;
	end

	always_ff @(posedge clk) begin
		if (load_addr)
			data_addr <= datapath_out[ADDR_W-1:0]; // effective address from C
	end

	assign mem_addr = addr_from_pc ? pc : data_addr;

	always_comb begin
		case (reg_sel)
			SEL_RN: reg_num = instr.r.rn;
			SEL_RD: reg_num = instr.r.rd;
			SEL_RM: reg_num = instr.r.rm;
			default: reg_num = instr.r.rn;
		endcase
	end

	// one field choice serves both ports
	assign read_num = reg_num;
	assign write_num = reg_num;

	assign sximm5 = {{(WORD_W-5){instr.i.imm8[4]}}, instr.i.imm8[4:0]};
	assign sximm8 = {{(WORD_W-8){instr.i.imm8[7]}}, instr.i.imm8};

endmodule

//--- register_file.sv
// register file, eight words with one synchronous write port and one combinational read port
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
	input logic clk,
	input reg_num_t read_num,
	input reg_num_t write_num,
	input logic write,
	input word_t write_data,
	output word_t rd_data
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (write)
			regs[write_num] <= write_data;
	end

	assign rd_data = regs[read_num]; // visible in the same cycle

endmodule

//--- execute_unit.sv
// execute unit, operand registers, shifter, ALU, status flags and write-back select
`timescale 1ns/10ps

module execute_unit import cpu_pkg::*; (
	input logic clk,
	input ctrl_t ctrl,
	input word_t rd_data,
	input word_t sximm5,
	input word_t sximm8,
	input word_t read_data,
	input shift_t shift,
	input alu_op_t alu_op,
	output word_t write_data,
	output flags_t flags,
	output word_t datapath_out
);

	word_t a_reg;
	word_t b_reg;
	word_t c_reg;
	word_t shifted;
	word_t b_next;
	word_t a_in;
	word_t b_in;
	word_t alu_out;
	logic ovf;

	always_comb begin
		case (shift)
			SH_NONE: shifted = rd_data;
			SH_LSL: shifted = {rd_data[WORD_W-2:0], 1'b0};
			SH_LSR: shifted = {1'b0, rd_data[WORD_W-1:1]};
			SH_ASR: shifted = {rd_data[WORD_W-1], rd_data[WORD_W-1:1]};
			default: shifted = rd_data;
		endcase
	end

	// the shift field only applies to the Rm operand
	assign b_next = (ctrl.reg_sel == SEL_RM) ? shifted : rd_data;

	assign a_in = ctrl.a_zero ? '0 : a_reg;
	assign b_in = ctrl.b_imm ? sximm5 : b_reg;

	always_comb begin
		case (alu_op)
			ADD: alu_out = a_in + b_in;
			SUB: alu_out = a_in - b_in;
			AND: alu_out = a_in & b_in;
			NOT_B: alu_out = ~b_in;
			default: alu_out = a_in + b_in;
		endcase
	end

	// signed overflow, only add and subtract can set it
	always_comb begin
		case (alu_op)
			ADD: ovf = (a_in[WORD_W-1] == b_in[WORD_W-1]) && (alu_out[WORD_W-1] != a_in[WORD_W-1]);
			SUB: ovf = (a_in[WORD_W-1] != b_in[WORD_W-1]) && (alu_out[WORD_W-1] != a_in[WORD_W-1]);
			default: ovf = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ctrl.load_a)
			a_reg <= rd_data;
		if (ctrl.load_b)
			b_reg <= b_next;
		if (ctrl.load_c)
			c_reg <= alu_out;
		if (ctrl.load_s)
			flags <= '{z: (alu_out == '0), n: alu_out[WORD_W-1], v: ovf};
	end

	always_comb begin
		case (ctrl.wb_src)
			WB_C: write_data = c_reg;
			WB_IMM: write_data = sximm8;
			WB_MEM: write_data = read_data; // load data straight from memory
			default: write_data = c_reg;
		endcase
	end

	assign datapath_out = c_reg;

endmodule

//--- cpu.sv
// cpu top level, joins the control FSM with fetch/decode, register file and execute unit
`timescale 1ns/10ps

module cpu import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t read_data,
	output mem_cmd_t mem_cmd,
	output addr_t mem_addr,
	output word_t datapath_out,
	output logic halt
);

	ctrl_t ctrl;
	instr_t instr;
	flags_t flags;
	logic load_ir;
	logic load_pc;
	logic reset_pc;
	logic take_branch;
	logic addr_from_pc;
	logic load_addr;
	reg_num_t read_num;
	reg_num_t write_num;
	word_t sximm5;
	word_t sximm8;
	word_t rd_data;
	word_t write_data;

	cpu_control control_i (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.flags(flags),
		.ctrl(ctrl),
		.load_ir(load_ir),
		.load_pc(load_pc),
		.reset_pc(reset_pc),
		.take_branch(take_branch),
		.addr_from_pc(addr_from_pc),
		.load_addr(load_addr),
		.mem_cmd(mem_cmd),
		.halt(halt)
	);

	fetch_decode fetch_i (
		.clk(clk),
		.read_data(read_data),
		.datapath_out(datapath_out),
		.reg_sel(ctrl.reg_sel),
		.load_ir(load_ir),
		.load_pc(load_pc),
		.reset_pc(reset_pc),
		.take_branch(take_branch),
		.addr_from_pc(addr_from_pc),
		.load_addr(load_addr),
		.instr(instr),
		.read_num(read_num),
		.write_num(write_num),
		.sximm5(sximm5),
		.sximm8(sximm8),
		.mem_addr(mem_addr)
	);

	register_file regs_i (
		.clk(clk),
		.read_num(read_num),
		.write_num(write_num),
		.write(ctrl.write),
		.write_data(write_data),
		.rd_data(rd_data)
	);

	execute_unit exec_i (
		.clk(clk),
		.ctrl(ctrl),
		.rd_data(rd_data),
		.sximm5(sximm5),
		.sximm8(sximm8),
		.read_data(read_data),
		.shift(instr.r.shift),
		.alu_op(instr.r.op),
		.write_data(write_data),
		.flags(flags),
		.datapath_out(datapath_out)
	);

endmodule

//--- cpu_asserts.sv
// cpu control assertions, memory command encoding, halt behavior and write exclusion
`timescale 1ns/10ps

module cpu_asserts import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input mem_cmd_t mem_cmd,
	input logic halt,
	input logic reg_write
);

	assert property (@(posedge clk) disable iff (reset) mem_cmd != 2'b11)
		else $error("mem_cmd carries the unused encoding");

	assert property (@(posedge clk) disable iff (reset) halt |-> mem_cmd == MNONE)
		else $error("memory command issued while halted");

	assert property (@(posedge clk) disable iff (reset) halt |=> halt)
		else $error("halt dropped without reset");

	// a store never overlaps a register write back
	assert property (@(posedge clk) disable iff (reset) !(mem_cmd == MWRITE && reg_write))
		else $error("memory write and register write in the same cycle");

endmodule

bind cpu_control cpu_asserts asserts_i (
	.clk(clk),
	.reset(reset),
	.mem_cmd(mem_cmd),
	.halt(halt),
	.reg_write(ctrl.write)
);

//--- tb_cpu.sv
// cpu testbench, memory model, stimulus file reader, store checks and watchdog
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int SETTLE_CYCLES = 20; // cycles watched after halt
	localparam int MEM_WORDS = 512;

	logic clk;
	logic reset;
	word_t read_data;
	mem_cmd_t mem_cmd;
	addr_t mem_addr;
	word_t datapath_out;
	logic halt;

	word_t mem [MEM_WORDS];
	addr_t exp_addr [$];
	word_t exp_data [$];
	int budget;
	int value_errors;
	int other_errors;
	int n_writes;
	logic stim_ok;
	logic stim_loaded;
	logic halt_seen;
	logic first_read_seen;
	logic prev_write;
	addr_t prev_addr;
	word_t prev_data;

	cpu cpu_i (
		.clk(clk),
		.reset(reset),
		.read_data(read_data),
		.mem_cmd(mem_cmd),
		.mem_addr(mem_addr),
		.datapath_out(datapath_out),
		.halt(halt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// single port pair memory, data shows up the cycle after the address
	always @(posedge clk) begin
		if (mem_cmd == MWRITE)
			mem[mem_addr] <= datapath_out;
		if (mem_cmd == MREAD)
			read_data <= mem[mem_addr];
	end

	task automatic report_mismatch(input string what, input word_t got, input word_t exp);
		$display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
		value_errors++;
	endtask

	// M addr data, W addr data, C cycles, # starts a comment
	task automatic load_stimulus();
		int fd;
		int ch;
		int rc;
		logic [15:0] a;
		logic [15:0] d;
		fd = $fopen("cpu_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open cpu_stim.txt");
			stim_ok = 1'b0;
		end else begin
			ch = $fgetc(fd);
			while (ch != -1) begin
				if (ch == "#") begin
					while (ch != -1 && ch != "\n")
						ch = $fgetc(fd);
				end else if (ch == "M") begin
					rc = $fscanf(fd, "%h %h", a, d);
					if (rc == 2) begin
						mem[a[ADDR_W-1:0]] <= d;
					end else begin
						$display("memory line in cpu_stim.txt lacks address or data");
						stim_ok = 1'b0;
					end
				end else if (ch == "W") begin
					rc = $fscanf(fd, "%h %h", a, d);
					if (rc == 2) begin
						exp_addr.push_back(a[ADDR_W-1:0]);
						exp_data.push_back(d);
					end else begin
						$display("write line in cpu_stim.txt lacks address or data");
						stim_ok = 1'b0;
					end
				end else if (ch == "C") begin
					rc = $fscanf(fd, "%d", budget);
					if (rc != 1) begin
						$display("cycle line in cpu_stim.txt lacks a number");
						stim_ok = 1'b0;
					end
				end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
					$display("unknown line kind in cpu_stim.txt");
					stim_ok = 1'b0;
				end
				ch = $fgetc(fd);
			end
			$fclose(fd);
			if (budget <= 0) begin
				$display("cpu_stim.txt gives no cycle budget");
				stim_ok = 1'b0;
			end
		end
	endtask

	task automatic check_idle(input string when);
		assert (halt == 1'b0 && mem_cmd == MNONE) else begin
			$display("FAIL %0t: outputs not idle %s, halt %b mem_cmd %0d",
				$time, when, halt, mem_cmd);
			value_errors++;
		end
	endtask

	// first cycle of a store, the second cycle only repeats it
	task automatic compare_write();
		if (halt_seen) begin
			$display("store to %h issued after halt at %0t", mem_addr, $time);
			other_errors++;
		end else if (n_writes >= exp_addr.size()) begin
			$display("unexpected extra store to %h at %0t", mem_addr, $time);
			other_errors++;
		end else begin
			assert (mem_addr == exp_addr[n_writes])
				else report_mismatch("store address", word_t'(mem_addr),
					word_t'(exp_addr[n_writes]));
			assert (datapath_out == exp_data[n_writes])
				else report_mismatch("store data", datapath_out, exp_data[n_writes]);
		end
		n_writes++;
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			if (!first_read_seen && mem_cmd == MREAD) begin
				first_read_seen = 1'b1;
				assert (mem_addr == 9'h000)
					else report_mismatch("first fetch address", word_t'(mem_addr), 16'h0000);
			end
			if (halt_seen) begin
				assert (halt) else begin
					$display("halt dropped without reset at %0t", $time);
					other_errors++;
				end
			end
			if (halt)
				halt_seen = 1'b1;
			if (mem_cmd == MWRITE) begin
				if (prev_write) begin
					assert (mem_addr == prev_addr && datapath_out == prev_data)
						else report_mismatch("repeated store data", datapath_out, prev_data);
				end else begin
					compare_write();
				end
			end
			prev_write = (mem_cmd == MWRITE);
			prev_addr = mem_addr;
			prev_data = datapath_out;
		end
	end

	// watchdog, the budget in the stimulus file covers reset, program and settle time
	initial begin
		wait (stim_loaded);
		#(budget * CLK_PERIOD);
		$display("timeout after %0d cycles, halt %s reached, errors: %0d value, %0d other, %s",
			budget, halt_seen ? "was" : "not", value_errors, other_errors,
			$sformatf("stores %0d of %0d", n_writes, exp_addr.size()));
		$display("Simulation failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		read_data = '0;
		budget = 0;
		value_errors = 0;
		other_errors = 0;
		n_writes = 0;
		stim_ok = 1'b1;
		stim_loaded = 1'b0;
		halt_seen = 1'b0;
		first_read_seen = 1'b0;
		prev_write = 1'b0;
		prev_addr = '0;
		prev_data = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] <= 16'hA500 ^ 16'(i); // background, overwritten by the image
		load_stimulus();
		if (!stim_ok) begin
			$display("stimulus file missing or malformed");
			$display("Simulation failed");
			$finish;
		end else begin
			stim_loaded = 1'b1;
			repeat (RESET_CYCLES - 1) begin
				@(negedge clk);
				check_idle("during reset");
			end
			@(posedge clk);
			reset <= 1'b0;
			@(negedge clk);
			check_idle("just after reset");
			wait (halt_seen);
			repeat (SETTLE_CYCLES) @(negedge clk);
			assert (n_writes == exp_addr.size()) else begin
				$display("store count wrong, saw %0d expected %0d", n_writes, exp_addr.size());
				other_errors++;
			end
			$display("errors: %0d value, %0d other, stores %0d of %0d",
				value_errors, other_errors, n_writes, exp_addr.size());
			if (value_errors == 0 && other_errors == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

//--- cpu_stim.txt
# M addr data: memory image word, W addr data: expected store in order
# C cycles: cycle budget for the whole run, hex for M and W, decimal for C
M 000 D760 # movi r7, 0x60
M 001 D005 # movi r0, 5
M 002 D1FD # movi r1, -3
M 003 C048 # mov r2, r0 lsl 1
M 004 A079 # add r3, r0, r1 asr 1
M 005 B182 # and r4, r1, r2
M 006 B8B2 # mvn r5, r2 lsr 1
M 007 8740 # str r2, [r7, 0]
M 008 8761 # str r3, [r7, 1]
M 009 8782 # str r4, [r7, 2]
M 00A 87A3 # str r5, [r7, 3]
M 00B A800 # cmp r0, r0
M 00C 2101 # beq taken
M 00D 8724 # str r1, [r7, 4] skipped
M 00E 2201 # bne not taken
M 00F 8705 # str r0, [r7, 5]
M 010 A900 # cmp r1, r0
M 011 2301 # blt taken
M 012 8726 # str r1, [r7, 6] skipped
M 013 A801 # cmp r0, r1
M 014 2401 # ble not taken
M 015 8767 # str r3, [r7, 7]
M 016 AB03 # cmp r3, r3
M 017 2401 # ble taken on equal
M 018 8728 # str r1, [r7, 8] skipped
M 019 2001 # b always
M 01A 8729 # str r1, [r7, 9] skipped
M 01B 67CF # ldr r6, [r7, 15]
M 01C 87CA # str r6, [r7, 10]
M 01D E000 # halt
M 01E 870B # str r0, [r7, 11] never reached
M 06F BEEF # load source
W 060 000A
W 061 0003
W 062 0008
W 063 FFFA
W 065 0005
W 067 0003
W 06A BEEF
C 400

//--- filelist.f
cpu_pkg.sv
cpu_control.sv
fetch_decode.sv
register_file.sv
execute_unit.sv
cpu.sv
cpu_asserts.sv
tb_cpu.sv
